/* design/port_stats_params.svh */
/* Widths, port counts, bank-local word offsets and the version/ID of the port statistics block.
   Included by the package and by every RTL file that sizes a port or a register. */

`ifndef PORT_STATS_PARAMS_SVH
`define PORT_STATS_PARAMS_SVH

// Register bus
`define PS_DATA_W           32
`define PS_ADDR_W           8

// Ports per direction and snapshot layout
`define PS_NUM_ING_PORTS    4
`define PS_NUM_EGR_PORTS    4
`define PS_CNTRS_PER_PORT   4
`define PS_CNT_W            32

// Identification word, version in the high half
`define PS_MODULE_ID        16'd10
`define PS_MODULE_VERSION   16'h0100

// Word offsets inside one direction's bank
`define PS_BANK_IDX_W       6
`define PS_BIDX_ENABLE_CON  0
`define PS_BIDX_ENABLE_STAT 1
`define PS_BIDX_COUNTER_CON 2
`define PS_BIDX_SNAP_BASE   3

`endif

/* design/port_stats_pkg.sv */
/* Types shared by the port statistics RTL and its testbench: opcodes, the register map,
   FSM states and the bus, bank and counter structs. */

`include "port_stats_params.svh"

package port_stats_pkg;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } bus_op_e;

    // Word addresses; enable, status and counter control words alternate ingress/egress
    typedef enum logic [`PS_ADDR_W-1:0] {
        REG_VERSION_ID      = `PS_ADDR_W'(0),
        REG_NUM_REGS        = `PS_ADDR_W'(1),
        REG_ING_ENABLE_CON  = `PS_ADDR_W'(2),
        REG_EGR_ENABLE_CON  = `PS_ADDR_W'(3),
        REG_ING_ENABLE_STAT = `PS_ADDR_W'(4),
        REG_EGR_ENABLE_STAT = `PS_ADDR_W'(5),
        REG_ING_COUNTER_CON = `PS_ADDR_W'(6),
        REG_EGR_COUNTER_CON = `PS_ADDR_W'(7),
        REG_ING_CNTRS_START = `PS_ADDR_W'(8),
        REG_EGR_CNTRS_START = `PS_ADDR_W'(8 + `PS_NUM_ING_PORTS * `PS_CNTRS_PER_PORT),
        REG_TOTAL           = `PS_ADDR_W'(8 + (`PS_NUM_ING_PORTS + `PS_NUM_EGR_PORTS)
                                              * `PS_CNTRS_PER_PORT)
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } fsm_state_e;

    // Word order inside one port's snapshot
    typedef enum logic [1:0] {
        SNAP_PKT   = 2'd0,
        SNAP_BYTES = 2'd1,
        SNAP_ERR   = 2'd2,
        SNAP_DROP  = 2'd3
    } snap_field_e;

    typedef struct packed {
        bus_op_e                op;
        logic [`PS_ADDR_W-1:0]  addr;
        logic [`PS_DATA_W-1:0]  wdata;
    } bus_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   error;
        logic [`PS_DATA_W-1:0]  rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [`PS_CNT_W-1:0]   pkt;
        logic [`PS_CNT_W-1:0]   bytes;
        logic [`PS_CNT_W-1:0]   err;
    } port_cnts_t;

    // One access from the FSM to a bank, index is the bank-local word
    typedef struct packed {
        logic                       wr;
        logic                       rd;
        logic [`PS_BANK_IDX_W-1:0]  index;
        logic [`PS_DATA_W-1:0]      wdata;
    } bank_req_t;

endpackage

/* design/reg_access_fsm.sv */
/* Register bus front end: accepts one request at a time, decodes the word address into a
   constant or a bank access, and answers two cycles after the accept. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module reg_access_fsm (
    input  logic                        core_clk_ifc,
    input  logic                        peripheral_sresetn_core,
    input  port_stats_pkg::bus_req_t    req,
    input  logic [`PS_DATA_W-1:0]       ing_rdata,
    input  logic [`PS_DATA_W-1:0]       egr_rdata,
    output port_stats_pkg::bus_rsp_t    rsp,
    output logic                        busy,
    output port_stats_pkg::bank_req_t   ing_req,
    output port_stats_pkg::bank_req_t   egr_req
);

    port_stats_pkg::fsm_state_e state;

    logic                       accept;
    logic                       in_access;

    // Address decode of the incoming request
    logic                       dec_err;
    logic                       dec_ver;
    logic                       dec_num;
    logic                       dec_ing;
    logic                       dec_egr;
    logic [`PS_BANK_IDX_W-1:0]  dec_idx;

    // Request held for the access cycle
    logic                       rd_q;
    logic                       wr_q;
    logic                       err_q;
    logic                       ver_q;
    logic                       num_q;
    logic                       ing_q;
    logic                       egr_q;
    logic [`PS_BANK_IDX_W-1:0]  idx_q;
    logic [`PS_DATA_W-1:0]      wdata_q;
    logic [`PS_DATA_W-1:0]      rd_word;

    assign accept    = (state == port_stats_pkg::ST_IDLE) && (req.op != port_stats_pkg::OP_NONE);
    assign in_access = (state == port_stats_pkg::ST_ACCESS);
    assign busy      = (state != port_stats_pkg::ST_IDLE);

    always_comb begin
        dec_err = 1'b0;
        dec_ver = 1'b0;
        dec_num = 1'b0;
        dec_ing = 1'b0;
        dec_egr = 1'b0;
        dec_idx = '0;
        if (req.addr >= port_stats_pkg::REG_TOTAL) begin
            dec_err = 1'b1;
        end else if (req.addr >= port_stats_pkg::REG_EGR_CNTRS_START) begin
            dec_egr = 1'b1;
            dec_idx = `PS_BANK_IDX_W'(req.addr - port_stats_pkg::REG_EGR_CNTRS_START
                                      + `PS_BIDX_SNAP_BASE);
        end else if (req.addr >= port_stats_pkg::REG_ING_CNTRS_START) begin
            dec_ing = 1'b1;
            dec_idx = `PS_BANK_IDX_W'(req.addr - port_stats_pkg::REG_ING_CNTRS_START
                                      + `PS_BIDX_SNAP_BASE);
        end else if (req.addr >= port_stats_pkg::REG_ING_ENABLE_CON) begin
            // Even words go to ingress, odd words to egress
            dec_ing = ~req.addr[0];
            dec_egr = req.addr[0];
            dec_idx = `PS_BANK_IDX_W'((req.addr - port_stats_pkg::REG_ING_ENABLE_CON) >> 1);
        end else if (req.addr == port_stats_pkg::REG_NUM_REGS) begin
            dec_num = 1'b1;
        end else begin
            dec_ver = 1'b1;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            rd_q    <= (req.op == port_stats_pkg::OP_READ);
            wr_q    <= (req.op == port_stats_pkg::OP_WRITE);
            err_q   <= dec_err;
            ver_q   <= dec_ver;
            num_q   <= dec_num;
            ing_q   <= dec_ing;
            egr_q   <= dec_egr;
            idx_q   <= dec_idx;
            wdata_q <= req.wdata;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Access cycle
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        ing_req       = '0;
        egr_req       = '0;
        ing_req.wr    = in_access & wr_q & ing_q;
        ing_req.rd    = in_access & rd_q & ing_q;
        ing_req.index = idx_q;
        ing_req.wdata = wdata_q;
        egr_req.wr    = in_access & wr_q & egr_q;
        egr_req.rd    = in_access & rd_q & egr_q;
        egr_req.index = idx_q;
        egr_req.wdata = wdata_q;
    end

    // Nothing selected on an error, so the word stays zero
    always_comb begin
        rd_word = '0;
        if (ing_q) begin
            rd_word = ing_rdata;
        end else if (egr_q) begin
            rd_word = egr_rdata;
        end else if (ver_q) begin
            rd_word = {`PS_MODULE_VERSION, `PS_MODULE_ID};
        end else if (num_q) begin
            rd_word = `PS_DATA_W'(port_stats_pkg::REG_TOTAL);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state <= port_stats_pkg::ST_IDLE;
            rsp   <= '0;
        end else begin
            rsp <= '0;
            case (state)
                port_stats_pkg::ST_IDLE: begin
                    if (accept) begin
                        state <= port_stats_pkg::ST_ACCESS;
                    end
                end
                port_stats_pkg::ST_ACCESS: begin
                    state     <= port_stats_pkg::ST_RESPOND;
                    rsp.valid <= 1'b1;
                    rsp.error <= err_q;
                    rsp.rdata <= rd_q ? rd_word : '0;
                end
                default: begin
                    state <= port_stats_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/drop_event_counter.sv */
/* Counts rising edges of each port's buffer-full drop level; a port's count restarts
   when the bank takes its snapshot. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module drop_event_counter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  logic [NUM_PORTS-1:0]                    buf_full_drop,
    input  logic [NUM_PORTS-1:0]                    snap,
    output logic [NUM_PORTS-1:0][`PS_CNT_W-1:0]     drop_cnt
);

    logic [NUM_PORTS-1:0] drop_q;
    logic [NUM_PORTS-1:0] drop_rise;

    assign drop_rise = buf_full_drop & ~drop_q;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_q   <= '0;
            drop_cnt <= '0;
        end else begin
            drop_q <= buf_full_drop;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (snap[p]) begin
                    // Old count goes to the snapshot, an edge in the same cycle is kept
                    drop_cnt[p] <= drop_rise[p] ? `PS_CNT_W'(1) : '0;
                end else if (drop_rise[p]) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

/* design/port_stats_bank.sv */
/* One direction's registers: port enables, enable status, counter control and the per-port
   snapshot words. Instantiated once for ingress and once for egress. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module port_stats_bank #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  port_stats_pkg::bank_req_t               bank_req,
    output logic [`PS_DATA_W-1:0]                   rdata,
    output logic [NUM_PORTS-1:0]                    port_enable,
    input  logic [NUM_PORTS-1:0]                    port_connected,
    input  port_stats_pkg::port_cnts_t [NUM_PORTS-1:0] cnts,
    input  logic [NUM_PORTS-1:0]                    buf_full_drop,
    output logic [NUM_PORTS-1:0]                    cnts_clear
);

    localparam int NUM_SNAP = NUM_PORTS * `PS_CNTRS_PER_PORT;
    localparam int FIELD_W  = $clog2(`PS_CNTRS_PER_PORT);
    localparam int PORT_W   = $clog2(NUM_PORTS);

    logic [NUM_PORTS-1:0]   enable_con;
    logic [NUM_PORTS-1:0]   counter_con;
    logic [NUM_PORTS-1:0]   counter_con_q;
    logic [NUM_PORTS-1:0]   snap;

    logic [NUM_PORTS-1:0][`PS_CNT_W-1:0]                        drop_cnt;
    logic [NUM_PORTS-1:0][`PS_CNTRS_PER_PORT-1:0][`PS_CNT_W-1:0] snap_words;

    // Read select inside the snapshot area
    logic [`PS_BANK_IDX_W-1:0]  snap_off;
    logic [PORT_W-1:0]          snap_port;
    logic [FIELD_W-1:0]         snap_field;

    assign port_enable = enable_con;

    ///////////////////////////////////////////////////////////////////////
    // Control registers
    ///////////////////////////////////////////////////////////////////////

    // Only the two control words take writes
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            enable_con  <= '1;
            counter_con <= '0;
        end else if (bank_req.wr) begin
            case (bank_req.index)
                `PS_BANK_IDX_W'(`PS_BIDX_ENABLE_CON): begin
                    enable_con <= bank_req.wdata[NUM_PORTS-1:0];
                end
                `PS_BANK_IDX_W'(`PS_BIDX_COUNTER_CON): begin
                    counter_con <= bank_req.wdata[NUM_PORTS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Snapshot on a rising counter control bit
    ///////////////////////////////////////////////////////////////////////

    assign snap = counter_con & ~counter_con_q;

    drop_event_counter #(
        .NUM_PORTS  ( NUM_PORTS )
    ) drop_counter (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .buf_full_drop           ( buf_full_drop           ),
        .snap                    ( snap                    ),
        .drop_cnt                ( drop_cnt                )
    );

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            counter_con_q <= '0;
            cnts_clear    <= '0;
            snap_words    <= '0;
        end else begin
            counter_con_q <= counter_con;
            // External counters restart the cycle after they are captured
            cnts_clear    <= snap;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (snap[p]) begin
                    snap_words[p][port_stats_pkg::SNAP_PKT]   <= cnts[p].pkt;
                    snap_words[p][port_stats_pkg::SNAP_BYTES] <= cnts[p].bytes;
                    snap_words[p][port_stats_pkg::SNAP_ERR]   <= cnts[p].err;
                    snap_words[p][port_stats_pkg::SNAP_DROP]  <= drop_cnt[p];
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Read-back
    ///////////////////////////////////////////////////////////////////////

    assign snap_off   = bank_req.index - `PS_BANK_IDX_W'(`PS_BIDX_SNAP_BASE);
    assign snap_port  = PORT_W'(snap_off >> FIELD_W);
    assign snap_field = FIELD_W'(snap_off);

    always_comb begin
        rdata = '0;
        if (bank_req.rd) begin
            if (bank_req.index == `PS_BANK_IDX_W'(`PS_BIDX_ENABLE_CON)) begin
                rdata = `PS_DATA_W'(enable_con);
            end else if (bank_req.index == `PS_BANK_IDX_W'(`PS_BIDX_ENABLE_STAT)) begin
                rdata = `PS_DATA_W'(port_connected);
            end else if (bank_req.index == `PS_BANK_IDX_W'(`PS_BIDX_COUNTER_CON)) begin
                rdata = `PS_DATA_W'(counter_con);
            end else if (snap_off < `PS_BANK_IDX_W'(NUM_SNAP)) begin
                rdata = snap_words[snap_port][snap_field];
            end
        end
    end

endmodule

/* design/port_stats_top.sv */
/* Port statistics register block: the bus FSM in front of one ingress and one egress bank,
   all in the core clock domain. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module port_stats_top (
    input  logic                                            core_clk_ifc,
    input  logic                                            peripheral_sresetn_core,
    input  port_stats_pkg::bus_req_t                        req,
    output port_stats_pkg::bus_rsp_t                        rsp,
    output logic                                            busy,
    // Ingress ports
    output logic [`PS_NUM_ING_PORTS-1:0]                    ing_port_enable,
    input  logic [`PS_NUM_ING_PORTS-1:0]                    ing_port_connected,
    output logic [`PS_NUM_ING_PORTS-1:0]                    ing_cnts_clear,
    input  port_stats_pkg::port_cnts_t [`PS_NUM_ING_PORTS-1:0] ing_cnts,
    input  logic [`PS_NUM_ING_PORTS-1:0]                    ing_buf_full_drop,
    // Egress ports
    output logic [`PS_NUM_EGR_PORTS-1:0]                    egr_port_enable,
    input  logic [`PS_NUM_EGR_PORTS-1:0]                    egr_port_connected,
    output logic [`PS_NUM_EGR_PORTS-1:0]                    egr_cnts_clear,
    input  port_stats_pkg::port_cnts_t [`PS_NUM_EGR_PORTS-1:0] egr_cnts,
    input  logic [`PS_NUM_EGR_PORTS-1:0]                    egr_buf_full_drop
);

    port_stats_pkg::bank_req_t  ing_req;
    port_stats_pkg::bank_req_t  egr_req;
    logic [`PS_DATA_W-1:0]      ing_rdata;
    logic [`PS_DATA_W-1:0]      egr_rdata;

    reg_access_fsm access_fsm (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req                     ( req                     ),
        .ing_rdata               ( ing_rdata               ),
        .egr_rdata               ( egr_rdata               ),
        .rsp                     ( rsp                     ),
        .busy                    ( busy                    ),
        .ing_req                 ( ing_req                 ),
        .egr_req                 ( egr_req                 )
    );

    port_stats_bank #(
        .NUM_PORTS  ( `PS_NUM_ING_PORTS )
    ) ing_bank (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bank_req                ( ing_req                 ),
        .rdata                   ( ing_rdata               ),
        .port_enable             ( ing_port_enable         ),
        .port_connected          ( ing_port_connected      ),
        .cnts                    ( ing_cnts                ),
        .buf_full_drop           ( ing_buf_full_drop       ),
        .cnts_clear              ( ing_cnts_clear          )
    );

    port_stats_bank #(
        .NUM_PORTS  ( `PS_NUM_EGR_PORTS )
    ) egr_bank (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bank_req                ( egr_req                 ),
        .rdata                   ( egr_rdata               ),
        .port_enable             ( egr_port_enable         ),
        .port_connected          ( egr_port_connected      ),
        .cnts                    ( egr_cnts                ),
        .buf_full_drop           ( egr_buf_full_drop       ),
        .cnts_clear              ( egr_cnts_clear          )
    );

endmodule

/* sim/port_stats_properties.sv */
/* Concurrent checks on bus timing and reset values of the port statistics block,
   bound into the top level. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module port_stats_properties (
    input logic                             core_clk_ifc,
    input logic                             peripheral_sresetn_core,
    input port_stats_pkg::bus_req_t         req,
    input port_stats_pkg::bus_rsp_t         rsp,
    input logic                             busy,
    input logic [`PS_NUM_ING_PORTS-1:0]     ing_cnts_clear,
    input logic [`PS_NUM_EGR_PORTS-1:0]     egr_cnts_clear
);

    logic accept;

    assign accept = !busy && (req.op != port_stats_pkg::OP_NONE);

    // Response exactly two cycles after the accept
    response_latency: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp.valid == $past(accept, 2)
    ) else $error("Response not two cycles after the accept");

    busy_after_reset: assert property (
        @(posedge core_clk_ifc) !peripheral_sresetn_core |=> !busy
    ) else $error("Busy high after reset");

    error_rdata_zero: assert property (
        @(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp.error |-> (rsp.rdata == '0)
    ) else $error("Error response with nonzero read data");

    no_clear_after_reset: assert property (
        @(posedge core_clk_ifc) !peripheral_sresetn_core |=>
        (ing_cnts_clear == '0 && egr_cnts_clear == '0)
    ) else $error("Counter clear pulse in the first cycle after reset");

endmodule

bind port_stats_top port_stats_properties props (
    .core_clk_ifc            ( core_clk_ifc            ),
    .peripheral_sresetn_core ( peripheral_sresetn_core ),
    .req                     ( req                     ),
    .rsp                     ( rsp                     ),
    .busy                    ( busy                    ),
    .ing_cnts_clear          ( ing_cnts_clear          ),
    .egr_cnts_clear          ( egr_cnts_clear          )
);

/* sim/port_stats_tb.sv */
/* Table-driven testbench for the port statistics block. Builds the access table with its
   expected values from a small register model, then applies it row by row to the DUT. */

`timescale 1ns/1ps

`include "port_stats_params.svh"

module port_stats_tb;

    localparam int MAX_ROWS = 256;
    localparam int NUM_SETS = 2;
    localparam int NP       = `PS_NUM_ING_PORTS;

    typedef enum logic [1:0] {
        ACT_SET_CNTS,
        ACT_PULSE_DROPS,
        ACT_WRITE,
        ACT_READ
    } action_e;

    // For drop pulses addr is the port (egress from NP up) and data the pulse count
    typedef struct packed {
        action_e                act;
        logic [`PS_ADDR_W-1:0]  addr;
        logic [`PS_DATA_W-1:0]  data;
        logic [`PS_DATA_W-1:0]  exp_rdata;
        logic                   exp_err;
        logic [2*NP-1:0]        exp_en;
        logic [2*NP-1:0]        exp_clr;
    } row_t;

    logic                                   core_clk_ifc;
    logic                                   peripheral_sresetn_core;
    port_stats_pkg::bus_req_t               req;
    port_stats_pkg::bus_rsp_t               rsp;
    logic                                   busy;
    logic [NP-1:0]                          ing_port_enable;
    logic [NP-1:0]                          ing_port_connected;
    logic [NP-1:0]                          ing_cnts_clear;
    port_stats_pkg::port_cnts_t [NP-1:0]    ing_cnts;
    logic [NP-1:0]                          ing_buf_full_drop;
    logic [NP-1:0]                          egr_port_enable;
    logic [NP-1:0]                          egr_port_connected;
    logic [NP-1:0]                          egr_cnts_clear;
    port_stats_pkg::port_cnts_t [NP-1:0]    egr_cnts;
    logic [NP-1:0]                          egr_buf_full_drop;

    row_t   rows [MAX_ROWS];
    int     num_rows    = 0;
    int     cycles      = 0;
    int     cycle_limit = 100;

    // Register model, index 0 ingress and 1 egress
    port_stats_pkg::port_cnts_t [NP-1:0]    cnt_sets [NUM_SETS][2];
    logic [NP-1:0]                          m_en [2];
    logic [NP-1:0]                          m_cc [2];
    logic [`PS_CNT_W-1:0]                   m_snap [2][NP][`PS_CNTRS_PER_PORT];
    logic [`PS_CNT_W-1:0]                   m_drop [2][NP];
    int                                     m_set;

    assign ing_port_connected = ing_port_enable;
    assign egr_port_connected = egr_port_enable;

    port_stats_top uut (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #5 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles before the table was finished", cycles);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Table construction
    ///////////////////////////////////////////////////////////////////////

    function automatic logic [`PS_DATA_W-1:0] expected_read(input int addr);
        int dir;
        int off;
        expected_read = '0;
        if (addr == 0) begin
            expected_read = {16'h0100, 16'd10};
        end else if (addr == 1) begin
            expected_read = 32'd40;
        end else if (addr >= 2 && addr < 8) begin
            dir = addr % 2;
            case ((addr - 2) / 2)
                0, 1: expected_read = 32'(m_en[dir]);
                default: expected_read = 32'(m_cc[dir]);
            endcase
        end else if (addr >= 8 && addr < 40) begin
            dir = (addr >= 24) ? 1 : 0;
            off = addr - 8 - 16 * dir;
            expected_read = m_snap[dir][off / 4][off % 4];
        end
    endfunction

    task automatic add_row(input action_e act, input int addr, input logic [31:0] data,
                           input logic [31:0] exp_rdata, input logic exp_err,
                           input logic [2*NP-1:0] exp_clr);
        rows[num_rows].act       = act;
        rows[num_rows].addr      = addr[`PS_ADDR_W-1:0];
        rows[num_rows].data      = data;
        rows[num_rows].exp_rdata = exp_rdata;
        rows[num_rows].exp_err   = exp_err;
        rows[num_rows].exp_en    = {m_en[1], m_en[0]};
        rows[num_rows].exp_clr   = exp_clr;
        num_rows++;
    endtask

    task automatic add_read(input int addr);
        add_row(ACT_READ, addr, '0, expected_read(addr), addr >= 40, '0);
    endtask

    // Rising counter control bits capture the driven counts and the drop count
    task automatic add_write(input int addr, input logic [31:0] data);
        int              dir;
        logic [NP-1:0]   rise;
        logic [2*NP-1:0] clr;
        clr = '0;
        if (addr >= 2 && addr < 8) begin
            dir = addr % 2;
            if (addr < 4) begin
                m_en[dir] = data[NP-1:0];
            end else if (addr >= 6) begin
                rise = data[NP-1:0] & ~m_cc[dir];
                for (int p = 0; p < NP; p++) begin
                    if (rise[p]) begin
                        m_snap[dir][p][port_stats_pkg::SNAP_PKT]   = cnt_sets[m_set][dir][p].pkt;
                        m_snap[dir][p][port_stats_pkg::SNAP_BYTES] = cnt_sets[m_set][dir][p].bytes;
                        m_snap[dir][p][port_stats_pkg::SNAP_ERR]   = cnt_sets[m_set][dir][p].err;
                        m_snap[dir][p][port_stats_pkg::SNAP_DROP]  = m_drop[dir][p];
                        m_drop[dir][p] = '0;
                    end
                end
                m_cc[dir] = data[NP-1:0];
                clr[dir*NP +: NP] = rise;
            end
        end
        add_row(ACT_WRITE, addr, data, '0, addr >= 40, clr);
    endtask

    task automatic snap_all();
        add_write(6, 32'h0);
        add_write(7, 32'h0);
        add_write(6, 32'hF);
        add_write(7, 32'hF);
    endtask

    task automatic read_snapshots();
        for (int a = 8; a < 40; a++) begin
            add_read(a);
        end
    endtask

    task automatic read_drop_words();
        for (int d = 0; d < 2; d++) begin
            for (int p = 0; p < NP; p++) begin
                add_read(8 + 16 * d + 4 * p + 3);
            end
        end
    endtask

    task automatic build_table();
        logic [NP-1:0] mask [2];
        void'($urandom(32'hac83_b409));
        for (int d = 0; d < 2; d++) begin
            m_en[d] = '1;
            m_cc[d] = '0;
            mask[d] = NP'($urandom);
            for (int p = 0; p < NP; p++) begin
                m_drop[d][p] = '0;
                for (int f = 0; f < `PS_CNTRS_PER_PORT; f++) begin
                    m_snap[d][p][f] = '0;
                end
                for (int k = 0; k < NUM_SETS; k++) begin
                    cnt_sets[k][d][p].pkt   = $urandom;
                    cnt_sets[k][d][p].bytes = $urandom;
                    cnt_sets[k][d][p].err   = $urandom;
                end
            end
        end
        m_set = 0;
        // Reset values
        add_read(0);
        add_read(1);
        add_read(2);
        add_read(4);
        add_read(5);
        add_read(8);
        add_read(24);
        // Enable control, status is read-only
        add_write(2, 32'hA5);
        add_read(4);
        add_read(2);
        add_write(3, 32'h3);
        add_read(5);
        add_read(3);
        add_write(4, 32'h0);
        add_read(4);
        add_write(2, 32'hF);
        add_write(3, 32'hF);
        // First snapshot of every port
        add_row(ACT_SET_CNTS, 0, 32'd0, '0, 1'b0, '0);
        add_write(6, 32'hF);
        add_write(7, 32'hF);
        read_snapshots();
        // New counts with no rising bit, then a masked snapshot
        m_set = 1;
        add_row(ACT_SET_CNTS, 0, 32'd1, '0, 1'b0, '0);
        add_write(6, 32'(mask[0]));
        add_write(7, 32'(mask[1]));
        add_read(6);
        add_read(7);
        read_snapshots();
        add_write(6, 32'h0);
        add_write(7, 32'h0);
        add_write(6, 32'(mask[0]));
        add_write(7, 32'(mask[1]));
        read_snapshots();
        // Drop events, p+1 pulses on port p
        for (int d = 0; d < 2; d++) begin
            for (int p = 0; p < NP; p++) begin
                m_drop[d][p] = m_drop[d][p] + 32'(p + 1);
                add_row(ACT_PULSE_DROPS, d * NP + p, 32'(p + 1), '0, 1'b0, '0);
            end
        end
        snap_all();
        read_drop_words();
        snap_all();
        read_drop_words();
        // Outside the register map
        add_read(40);
        add_write(40, 32'h1234_5678);
        add_read(255);
        add_write(200, 32'hFFFF_FFFF);
        cycle_limit = 20 * num_rows + 100;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Row application
    ///////////////////////////////////////////////////////////////////////

    task automatic bus_access(input row_t r, output port_stats_pkg::bus_rsp_t got);
        req.op    <= (r.act == ACT_WRITE) ? port_stats_pkg::OP_WRITE : port_stats_pkg::OP_READ;
        req.addr  <= r.addr;
        req.wdata <= r.data;
        @(posedge core_clk_ifc);
        req <= '0;
        do begin
            @(posedge core_clk_ifc);
        end while (!rsp.valid);
        got = rsp;
    endtask

    task automatic pulse_drop(input int port, input int count);
        logic [2*NP-1:0] drop_mask;
        drop_mask = (2*NP)'(1) << port;
        for (int i = 0; i < count; i++) begin
            {egr_buf_full_drop, ing_buf_full_drop} <= drop_mask;
            @(posedge core_clk_ifc);
            {egr_buf_full_drop, ing_buf_full_drop} <= '0;
            @(posedge core_clk_ifc);
        end
    endtask

    task automatic apply_row(input row_t r);
        port_stats_pkg::bus_rsp_t got;
        case (r.act)
            ACT_SET_CNTS: begin
                ing_cnts <= cnt_sets[r.data][0];
                egr_cnts <= cnt_sets[r.data][1];
                @(posedge core_clk_ifc);
            end
            ACT_PULSE_DROPS: begin
                pulse_drop(r.addr, r.data);
            end
            default: begin
                bus_access(r, got);
                check_value("busy", 32'(busy), 32'd1);
                check_value("rsp.error", 32'(got.error), 32'(r.exp_err));
                check_value("rsp.rdata", got.rdata, r.exp_rdata);
                check_value("port_enable", 32'({egr_port_enable, ing_port_enable}),
                            32'(r.exp_en));
                // Counter clear pulses in the cycle after the response
                @(posedge core_clk_ifc);
                check_value("busy", 32'(busy), 32'd0);
                check_value("cnts_clear", 32'({egr_cnts_clear, ing_cnts_clear}),
                            32'(r.exp_clr));
            end
        endcase
    endtask

    initial begin
        peripheral_sresetn_core = 1'b0;
        req                     = '0;
        ing_cnts                = '0;
        egr_cnts                = '0;
        ing_buf_full_drop       = '0;
        egr_buf_full_drop       = '0;
        build_table();
        repeat (2) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/port_stats_pkg.sv
design/reg_access_fsm.sv
design/drop_event_counter.sv
design/port_stats_bank.sv
design/port_stats_top.sv
sim/port_stats_properties.sv
sim/port_stats_tb.sv

/* Makefile */
TOP = port_stats_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
